//--- filelist.f
+incdir+rtl
rtl/labo_pkg.sv
rtl/cpu_bus_decoder.sv
rtl/io_gpio.sv
rtl/work_ram.sv
rtl/video_timing.sv
rtl/video_pattern.sv
rtl/hdmi_labo_core.sv
test/tb_hdmi_labo_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the video lab core testbench with Verilator

TOP=tb_hdmi_labo_core
LOG=sim.log

verilator --binary --timing -f filelist.f --top-module $TOP -Mdir obj_dir -o $TOP
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/$TOP > $LOG 2>&1
status=$?
cat $LOG
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" $LOG; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" $LOG; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0

//--- test/tb_hdmi_labo_core.sv
// --------------------
// testbench for the video lab core
// plays the z80 bus master against ram and gpio, then checks sync
// timing and every pixel of one frame per test pattern
// --------------------
`timescale 1ns/10ps
`include "labo_settings.svh"

module tb_hdmi_labo_core;
	import labo_pkg::*;

	localparam int			clk_half	= 20;					// 40 ns pixel clock
	localparam int			line_cycles	= `H_TOTAL;
	localparam int			frame_cycles	= `H_TOTAL * `V_TOTAL;
	// about 420 bus ops of 6 clocks plus 4 patterns of up to 2 frames, with margin
	localparam int			max_cycles	= 12000;
	localparam int			ram_words	= 2 ** `RAM_ADDR_BITS;
	localparam cpu_data_t	gpio_base	= `IO_GPIO_BASE;
	localparam bus_req_t	bus_idle	= '{mreq_n: 1'b1, iorq_n: 1'b1, rd_n: 1'b1,
										wr_n: 1'b1, addr: 16'h0000, wdata: 8'h00};

	logic		clk_pixel;
	logic		ff_reset_n;
	bus_req_t	bus_req;
	cpu_data_t	gpi;
	cpu_data_t	rdata;
	cpu_data_t	gpo;
	video_out_t	video;

	// models of the bus side
	cpu_data_t	ram_model [0:ram_words-1];
	cpu_data_t	gpo_model	= 8'h00;
	cpu_data_t	color_model	= 8'h00;
	cpu_addr_t	ram_addrs [$];

	int			bus_errors		= 0;
	int			pixel_errors	= 0;
	int			timing_errors	= 0;
	int			other_errors	= 0;
	int			cycle_count		= 0;

	// pixel window handshake, request from main, done from the monitor
	logic		pixel_request	= 1'b0;
	logic		pixel_done		= 1'b0;
	logic		pixel_active	= 1'b0;
	logic		reset_checked	= 1'b0;
	string		pattern_test	= "pattern";
	int			px_x			= 0;		// own pixel count from de
	int			px_y			= 0;		// own line count from de and vs
	logic		p_prev_de		= 1'b0;
	logic		p_prev_vs		= 1'b0;
	video_out_t	pixel_exp;

	// timing monitor state
	int			de_run			= 0;
	int			hs_run			= 0;
	int			vs_run			= 0;
	int			since_hs		= 0;
	int			since_vs		= 0;
	int			frame_lines		= 0;
	int			frames_timed	= 0;
	logic		hs_seen			= 1'b0;
	logic		vs_seen			= 1'b0;
	video_out_t	t_prev			= '0;

	hdmi_labo_core dut (
		.clk_pixel	( clk_pixel	),
		.ff_reset_n	( ff_reset_n	),
		.bus		( bus_req	),
		.gpi		( gpi		),
		.rdata		( rdata		),
		.gpo		( gpo		),
		.video		( video		)
	);

	initial begin
		clk_pixel = 1'b0;
		forever #clk_half clk_pixel = ~clk_pixel;
	end

	// --------------------
	// reference functions
	// --------------------
	function automatic logic in_ram( input cpu_addr_t a );
		return a[15:14] == 2'b11;					// C000h-FFFFh
	endfunction

	function automatic logic in_gpio( input cpu_addr_t a );
		return a[7:1] == gpio_base[7:1];			// low byte only
	endfunction

	// what a read of this address must return
	function automatic cpu_data_t read_expected( input logic is_mem, input cpu_addr_t a );
		if( is_mem ) begin
			return in_ram( a ) ? ram_model[ram_addr_t'( a )] : 8'hFF;
		end
		if( in_gpio( a ) ) begin
			return a[0] ? color_model : gpi;
		end
		return 8'hFF;								// unmapped port
	endfunction

	function automatic video_out_t expected_pixel( input pattern_mode_t mode, input cpu_data_t c,
			input logic hs, input logic vs, input logic de, input int x, input int y );
		video_out_t	p;
		coord_x_t	xb;
		coord_y_t	yb;
		xb		= coord_x_t'( x );
		yb		= coord_y_t'( y );
		p		= '0;
		p.hs	= hs;
		p.vs	= vs;
		p.de	= de;
		if( de ) begin
			case( mode )
				SOLID: begin
					p.r	= { c[7:5], c[7:5], c[7:6] };	// rgb332 widened
					p.g	= { c[4:2], c[4:2], c[4:3] };
					p.b	= { c[1:0], c[1:0], c[1:0], c[1:0] };
				end
				BARS: begin
					p.r	= xb[4] ? 8'hFF : 8'h00;
					p.g	= xb[3] ? 8'hFF : 8'h00;
					p.b	= xb[2] ? 8'hFF : 8'h00;
				end
				CHECKER: begin
					p.r	= ( xb[2] ^ yb[1] ) ? 8'hFF : 8'h00;
					p.g	= p.r;
					p.b	= p.r;
				end
				default: begin
				end
			endcase
		end
		return p;
	endfunction

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_data( input string name, input cpu_data_t exp, input cpu_data_t act );
		if( exp !== act ) begin
			$display( "Mismatch %s: expected %h, actual %h", name, exp, act );
			bus_errors++;
		end
	endtask

	task automatic check_pixel( input string name, input video_out_t exp, input video_out_t act );
		if( exp !== act ) begin
			$display( "Mismatch %s: expected %h, actual %h (x %0d y %0d)", name, exp, act,
				px_x, px_y );
			pixel_errors++;
		end
	endtask

	task automatic check_count( input string name, input coord_x_t exp, input coord_x_t act );
		if( exp !== act ) begin
			$display( "Mismatch %s: expected %0d, actual %0d", name, exp, act );
			timing_errors++;
		end
	endtask

	// --------------------
	// bus cycles, entered 2 ns after a rising edge
	// --------------------
	task automatic bus_cycle( input logic is_mem, input logic is_read, input cpu_addr_t a,
			input cpu_data_t wd, output cpu_data_t rd );
		bus_req	= '{mreq_n: !is_mem, iorq_n: is_mem, rd_n: !is_read, wr_n: is_read,
					addr: a, wdata: wd};
		repeat( 3 ) @( posedge clk_pixel );
		#1 rd = rdata;								// last of the 4 strobe cycles
		@( posedge clk_pixel );
		#2 bus_req = bus_idle;
		@( posedge clk_pixel );						// idle cycle
		#2;
	endtask

	task automatic mem_write( input cpu_addr_t a, input cpu_data_t d );
		cpu_data_t	unused;
		bus_cycle( 1'b1, 1'b0, a, d, unused );
		if( in_ram( a ) ) begin
			ram_model[ram_addr_t'( a )] = d;
		end
	endtask

	task automatic mem_read( input cpu_addr_t a, output cpu_data_t d );
		bus_cycle( 1'b1, 1'b1, a, 8'h00, d );
	endtask

	task automatic io_write( input cpu_addr_t a, input cpu_data_t d );
		cpu_data_t	unused;
		bus_cycle( 1'b0, 1'b0, a, d, unused );
		if( in_gpio( a ) && a[0] ) begin
			color_model = d;
		end
		else if( in_gpio( a ) ) begin
			gpo_model = d;
		end
	endtask

	task automatic io_read( input cpu_addr_t a, output cpu_data_t d );
		bus_cycle( 1'b0, 1'b1, a, 8'h00, d );
	endtask

	// --------------------
	// pixel compare, mid cycle
	// --------------------
	always @( negedge clk_pixel ) begin
		if( ff_reset_n ) begin
			if( !reset_checked ) begin
				check_pixel( "reset video", '0, video );	// syncs low before timing runs
				reset_checked = 1'b1;
			end
			if( !pixel_request ) begin
				pixel_done = 1'b0;
			end
			if( video.vs && !p_prev_vs ) begin
				if( pixel_active ) begin
					pixel_active	= 1'b0;				// one full frame seen
					pixel_done		= 1'b1;
				end
				else if( pixel_request && !pixel_done ) begin
					pixel_active	= 1'b1;
				end
			end
			if( pixel_active ) begin
				pixel_exp = expected_pixel( pattern_mode_t'( gpo_model[1:0] ), color_model,
					video.hs, video.vs, video.de, px_x, px_y );
				check_pixel( pattern_test, pixel_exp, video );
			end
			if( video.vs ) begin
				px_y = 0;
			end
			else if( p_prev_de && !video.de ) begin
				px_y++;								// end of an active line
			end
			px_x		= video.de ? px_x + 1 : 0;
			p_prev_de	= video.de;
			p_prev_vs	= video.vs;
		end
	end

	// --------------------
	// sync timing monitor
	// --------------------
	always @( negedge clk_pixel ) begin
		if( ff_reset_n ) begin
			since_hs++;
			since_vs++;
			if( video.de ) de_run++;
			if( video.hs ) hs_run++;
			if( video.vs ) vs_run++;
			if( t_prev.de && !video.de ) begin
				check_count( "de cycles per line", coord_x_t'( `H_ACTIVE ), coord_x_t'( de_run ) );
				de_run = 0;
				frame_lines++;
			end
			if( t_prev.hs && !video.hs ) begin
				check_count( "hs width", coord_x_t'( `H_SYNC ), coord_x_t'( hs_run ) );
				hs_run = 0;
			end
			if( video.hs && !t_prev.hs ) begin
				if( hs_seen ) begin
					check_count( "line period", coord_x_t'( line_cycles ), coord_x_t'( since_hs ) );
				end
				since_hs	= 0;
				hs_seen		= 1'b1;
			end
			if( t_prev.vs && !video.vs ) begin
				check_count( "vs width", coord_x_t'( `V_SYNC * line_cycles ), coord_x_t'( vs_run ) );
				vs_run = 0;
			end
			if( video.vs && !t_prev.vs ) begin
				if( vs_seen ) begin
					check_count( "frame period", coord_x_t'( frame_cycles ), coord_x_t'( since_vs ) );
					check_count( "active lines", coord_x_t'( `V_ACTIVE ), coord_x_t'( frame_lines ) );
					frames_timed++;
				end
				since_vs	= 0;
				frame_lines	= 0;
				vs_seen		= 1'b1;
			end
			t_prev = video;
		end
	end

	// run limit
	initial begin
		while( cycle_count < max_cycles ) begin
			@( posedge clk_pixel );
			cycle_count++;
		end
		$display( "Timeout: the run did not finish within %0d clock cycles", max_cycles );
		$display( "Simulation finished: FAIL" );
		$finish;
	end

	// --------------------
	// main sequence
	// --------------------
	initial begin
		cpu_addr_t	a;
		cpu_data_t	d;
		cpu_data_t	got;
		int			i;
		int			m;
		void'( $urandom( 32'hed2f ) );
		ff_reset_n	= 1'b0;
		bus_req		= bus_idle;
		gpi			= 8'h00;
		repeat( 5 ) @( posedge clk_pixel );
		#2 ff_reset_n = 1'b1;
		@( negedge clk_pixel );
		check_data( "reset rdata", 8'hFF, rdata );
		check_data( "reset gpo", 8'h00, gpo );
		@( posedge clk_pixel );
		#2;

		// ram, random writes then readback through a random 1 KB alias
		for( i = 0; i < 200; i++ ) begin
			a = cpu_addr_t'( $urandom() ) | 16'hC000;
			mem_write( a, cpu_data_t'( $urandom() ) );
			ram_addrs.push_back( a );
		end
		foreach( ram_addrs[k] ) begin
			a = { 2'b11, 4'( $urandom() ), ram_addrs[k][9:0] };
			mem_read( a, got );
			check_data( "ram readback", read_expected( 1'b1, a ), got );
		end
		mem_write( 16'hC155, 8'h5A );
		mem_read( 16'hF555, got );					// same word, top alias
		check_data( "ram alias", read_expected( 1'b1, 16'hF555 ), got );

		// gpio ports and colour register
		for( i = 0; i < 8; i++ ) begin
			io_write( 16'h0011, cpu_data_t'( $urandom() ) );
			io_read( 16'h0011, got );
			check_data( "colour register", read_expected( 1'b0, 16'h0011 ), got );
			gpi = cpu_data_t'( $urandom() );
			io_read( 16'h0010, got );
			check_data( "gpio input port", read_expected( 1'b0, 16'h0010 ), got );
			io_write( 16'h0010, cpu_data_t'( $urandom() ) );
			check_data( "gpio output port", gpo_model, gpo );
		end
		// last op above is a write and leaves the return register at FFh
		mem_read( 16'h0123, got );
		check_data( "rom space read", read_expected( 1'b1, 16'h0123 ), got );
		mem_read( 16'h4000, got );
		check_data( "unmapped memory read", read_expected( 1'b1, 16'h4000 ), got );
		io_read( 16'h0020, got );
		check_data( "unmapped port read", read_expected( 1'b0, 16'h0020 ), got );

		// patterns, one checked frame each
		for( m = 0; m < 4; m++ ) begin
			d = cpu_data_t'( $urandom() );
			io_write( 16'h0010, { d[7:2], m[1:0] } );
			io_write( 16'h0011, cpu_data_t'( $urandom() ) );
			pattern_test	= $sformatf( "pattern mode %0d", m );
			pixel_request	= 1'b1;
			wait( pixel_done );
			pixel_request	= 1'b0;
			wait( !pixel_done );
			@( posedge clk_pixel );
			#2;
		end

		if( frames_timed < 2 ) begin
			$display( "Timing monitor measured only %0d whole frames", frames_timed );
			other_errors++;
		end
		$display( "Errors: bus %0d, pixel %0d, timing %0d, other %0d",
			bus_errors, pixel_errors, timing_errors, other_errors );
		if( bus_errors + pixel_errors + timing_errors + other_errors == 0 ) begin
			$display( "Simulation finished: PASS" );
		end
		else begin
			$display( "Simulation finished: FAIL" );
		end
		$finish;
	end

endmodule

//--- rtl/hdmi_labo_core.sv
// --------------------
// video lab board core
// bus decoder and its peripherals on one side,
// sync generator and pattern drawer on the other, gpo picks the pattern
// --------------------
`timescale 1ns/10ps

module hdmi_labo_core (
	input							clk_pixel,
	input							ff_reset_n,
	input	labo_pkg::bus_req_t		bus,
	input	labo_pkg::cpu_data_t	gpi,
	output	labo_pkg::cpu_data_t	rdata,
	output	labo_pkg::cpu_data_t	gpo,
	output	labo_pkg::video_out_t	video
);
	import labo_pkg::*;

	logic			w_ram_sel;
	logic			w_io_sel;
	rd_return_t		w_ram_ret;
	rd_return_t		w_gpio_ret;
	cpu_data_t		w_color;
	video_pos_t		w_pos;

	// --------------------
	// bus side
	// --------------------
	cpu_bus_decoder u_decoder (
		.clk_pixel		( clk_pixel							),
		.ff_reset_n		( ff_reset_n						),
		.bus			( bus								),
		.ram_ret		( w_ram_ret							),
		.gpio_ret		( w_gpio_ret						),
		.ram_sel		( w_ram_sel							),
		.io_sel			( w_io_sel							),
		.rdata			( rdata								)
	);

	io_gpio u_gpio (
		.clk_pixel		( clk_pixel							),
		.ff_reset_n		( ff_reset_n						),
		.sel			( w_io_sel							),
		.reg_sel		( bus.addr[0]						),	// 10h port, 11h colour
		.rd_n			( bus.rd_n							),
		.wr_n			( bus.wr_n							),
		.wdata			( bus.wdata							),
		.gpi			( gpi								),
		.ret			( w_gpio_ret						),
		.gpo			( gpo								),
		.color			( w_color							)
	);

	work_ram u_ram (
		.clk_pixel		( clk_pixel							),
		.sel			( w_ram_sel							),
		.rd_n			( bus.rd_n							),
		.wr_n			( bus.wr_n							),
		.addr			( bus.addr[$bits( ram_addr_t )-1:0]	),	// aliases every 1 KB
		.wdata			( bus.wdata							),
		.ret			( w_ram_ret							)
	);

	// --------------------
	// video side
	// --------------------
	video_timing u_timing (
		.clk_pixel		( clk_pixel							),
		.ff_reset_n		( ff_reset_n						),
		.pos			( w_pos								)
	);

	video_pattern u_pattern (
		.clk_pixel		( clk_pixel							),
		.ff_reset_n		( ff_reset_n						),
		.pos			( w_pos								),
		.mode			( pattern_mode_t'( gpo[1:0] )		),
		.color			( w_color							),
		.video			( video								)
	);

endmodule

//--- rtl/video_pattern.sv
// --------------------
// test pattern drawer
// picks solid, colour bars, checker or blank per pixel and registers
// the colour together with the sync bits, one clock behind pos
// --------------------
`timescale 1ns/10ps

module video_pattern (
	input								clk_pixel,
	input								ff_reset_n,
	input	labo_pkg::video_pos_t		pos,
	input	labo_pkg::pattern_mode_t	mode,
	input	labo_pkg::cpu_data_t		color,		// rgb332
	output	labo_pkg::video_out_t		video
);
	import labo_pkg::*;

	color_t		w_r;
	color_t		w_g;
	color_t		w_b;
	logic [2:0]	w_bar;			// bar index, 4 pixels wide
	logic		w_check;
	video_out_t	ff_video;

	assign w_bar	= pos.x[4:2];
	assign w_check	= pos.x[2] ^ pos.y[1];

	// --------------------
	// pixel colour
	// --------------------
	always_comb begin
		w_r	= '0;
		w_g	= '0;
		w_b	= '0;
		if( pos.de ) begin				// black outside the active area
			case( mode )
				SOLID: begin
					// rgb332 widened by bit replication
					w_r	= { color[7:5], color[7:5], color[7:6] };
					w_g	= { color[4:2], color[4:2], color[4:3] };
					w_b	= { 4{ color[1:0] } };
				end
				BARS: begin
					w_r	= { 8{ w_bar[2] } };
					w_g	= { 8{ w_bar[1] } };
					w_b	= { 8{ w_bar[0] } };
				end
				CHECKER: begin
					w_r	= { 8{ w_check } };	// white or black
					w_g	= { 8{ w_check } };
					w_b	= { 8{ w_check } };
				end
				default: begin
					// blank, stays black
				end
			endcase
		end
	end

	// sync and colour leave on the same edge
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_video	<= '0;
		end
		else begin
			ff_video	<= '{ hs: pos.hs, vs: pos.vs, de: pos.de, r: w_r, g: w_g, b: w_b };
		end
	end

	assign video	= ff_video;

endmodule

//--- rtl/video_timing.sv
// --------------------
// video sync generator
// horizontal phase fsm with a counter per phase, plus a line counter
// pos is combinational from the counters and feeds the pattern stage
// --------------------
`timescale 1ns/10ps
`include "labo_settings.svh"

module video_timing (
	input							clk_pixel,
	input							ff_reset_n,
	output	labo_pkg::video_pos_t	pos
);
	import labo_pkg::*;

	// last count of each horizontal phase
	localparam coord_x_t	h_active_last	= coord_x_t'( `H_ACTIVE - 1 );
	localparam coord_x_t	h_front_last	= coord_x_t'( `H_FRONT - 1 );
	localparam coord_x_t	h_sync_last		= coord_x_t'( `H_SYNC - 1 );
	localparam coord_x_t	h_back_last		= coord_x_t'( `H_BACK - 1 );

	// vertical regions, in lines from the frame top
	localparam coord_y_t	v_active_end	= coord_y_t'( `V_ACTIVE );
	localparam coord_y_t	v_sync_start	= coord_y_t'( `V_ACTIVE + `V_FRONT );
	localparam coord_y_t	v_sync_end		= coord_y_t'( `V_ACTIVE + `V_FRONT + `V_SYNC );
	localparam coord_y_t	v_last			= coord_y_t'( `V_TOTAL - 1 );

	h_phase_t	ff_phase;
	h_phase_t	w_phase_next;
	coord_x_t	ff_h_cnt;			// position inside the phase
	coord_x_t	w_phase_last;
	coord_y_t	ff_v_cnt;			// line in frame
	logic		w_phase_end;
	logic		w_line_end;
	logic		w_v_active;
	logic		w_v_sync;

	// --------------------
	// horizontal phase fsm
	// --------------------
	always_comb begin
		case( ff_phase )
			ACTIVE: begin
				w_phase_last	= h_active_last;
				w_phase_next	= FRONT;
			end
			FRONT: begin
				w_phase_last	= h_front_last;
				w_phase_next	= SYNC;
			end
			SYNC: begin
				w_phase_last	= h_sync_last;
				w_phase_next	= BACK;
			end
			default: begin
				w_phase_last	= h_back_last;
				w_phase_next	= ACTIVE;		// wrap to next line
			end
		endcase
	end

	assign w_phase_end	= ( ff_h_cnt == w_phase_last );
	assign w_line_end	= w_phase_end && ( ff_phase == BACK );

	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_phase	<= ACTIVE;			// start drawing at once
			ff_h_cnt	<= '0;
		end
		else if( w_phase_end ) begin
			ff_phase	<= w_phase_next;
			ff_h_cnt	<= '0;
		end
		else begin
			ff_h_cnt	<= ff_h_cnt + 1'b1;
		end
	end

	// --------------------
	// vertical line counter
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_v_cnt	<= '0;
		end
		else if( w_line_end ) begin
			ff_v_cnt	<= ( ff_v_cnt == v_last ) ? '0 : ff_v_cnt + 1'b1;
		end
	end

	assign w_v_active	= ( ff_v_cnt < v_active_end );
	assign w_v_sync		= ( ff_v_cnt >= v_sync_start ) && ( ff_v_cnt < v_sync_end );

	// outputs
	assign pos.hs	= ( ff_phase == SYNC ) ? `HS_ACTIVE : ~`HS_ACTIVE;
	assign pos.vs	= w_v_sync ? `VS_ACTIVE : ~`VS_ACTIVE;
	assign pos.de	= ( ff_phase == ACTIVE ) && w_v_active;
	assign pos.x	= ( ff_phase == ACTIVE ) ? ff_h_cnt : '0;	// active-area x
	assign pos.y	= w_v_active ? ff_v_cnt : '0;

endmodule

//--- rtl/work_ram.sv
// --------------------
// 1 KB work ram on the memory bus
// synchronous write, registered read with a read-valid pulse
// the window aliases every 1 KB since only the low address bits come in
// --------------------
`timescale 1ns/10ps

module work_ram (
	input							clk_pixel,
	input							sel,
	input							rd_n,
	input							wr_n,
	input	labo_pkg::ram_addr_t	addr,
	input	labo_pkg::cpu_data_t	wdata,
	output	labo_pkg::rd_return_t	ret
);
	import labo_pkg::*;

	localparam int ram_words = 2 ** $bits( ram_addr_t );

	cpu_data_t	ff_mem [0:ram_words-1];		// contents survive reset
	cpu_data_t	ff_rd_data;
	logic		ff_rd_en;

	// --------------------
	// write port
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( sel && !wr_n ) begin
			ff_mem[addr]	<= wdata;
		end
	end

	// --------------------
	// read port
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		ff_rd_data	<= ff_mem[addr];
		ff_rd_en	<= sel && !rd_n;		// one pulse per read edge
	end

	assign ret.data	= ff_rd_data;
	assign ret.en	= ff_rd_en;

endmodule

//--- rtl/io_gpio.sv
// --------------------
// i/o mapped gpio block
// reg 0 reads the input port and writes the output port,
// reg 1 is the rgb332 colour register, read and write
// --------------------
`timescale 1ns/10ps

module io_gpio (
	input							clk_pixel,
	input							ff_reset_n,
	input							sel,			// decoded by the bus decoder
	input							reg_sel,		// addr[0]
	input							rd_n,
	input							wr_n,
	input	labo_pkg::cpu_data_t	wdata,
	input	labo_pkg::cpu_data_t	gpi,
	output	labo_pkg::rd_return_t	ret,
	output	labo_pkg::cpu_data_t	gpo,
	output	labo_pkg::cpu_data_t	color
);
	import labo_pkg::*;

	cpu_data_t	ff_gpo;
	cpu_data_t	ff_color;			// rgb332
	cpu_data_t	ff_rd_data;
	logic		ff_rd_en;

	// --------------------
	// write side
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_gpo		<= '0;
			ff_color	<= '0;
		end
		else if( sel && !wr_n ) begin
			if( reg_sel ) begin
				ff_color	<= wdata;
			end
			else begin
				ff_gpo		<= wdata;
			end
		end
	end

	// --------------------
	// read side
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_rd_en	<= 1'b0;
		end
		else begin
			ff_rd_en	<= sel && !rd_n;		// pulses every edge of the read
		end
	end

	// read data mux, follows reg_sel every edge
	always_ff @( posedge clk_pixel ) begin
		ff_rd_data	<= reg_sel ? ff_color : gpi;
	end

	assign ret.data	= ff_rd_data;
	assign ret.en	= ff_rd_en;
	assign gpo		= ff_gpo;
	assign color	= ff_color;

endmodule

//--- rtl/cpu_bus_decoder.sv
// --------------------
// z80 bus decoder and data return register
// turns mreq/iorq and the address into peripheral selects, then
// muxes the peripheral read answers onto one registered read bus
// --------------------
`timescale 1ns/10ps
`include "labo_settings.svh"

module cpu_bus_decoder (
	input							clk_pixel,
	input							ff_reset_n,
	input	labo_pkg::bus_req_t		bus,
	input	labo_pkg::rd_return_t	ram_ret,
	input	labo_pkg::rd_return_t	gpio_ret,
	output	logic					ram_sel,
	output	logic					io_sel,
	output	labo_pkg::cpu_data_t	rdata
);
	import labo_pkg::*;

	localparam cpu_data_t	io_base		= `IO_GPIO_BASE;
	localparam logic [1:0]	ram_window	= 2'b11;		// C000h-FFFFh

	cpu_data_t	ff_rdata;		// data bus return

	// --------------------
	// address decode
	// --------------------
	// memory side, the top quarter of the map is ram
	assign ram_sel	= !bus.mreq_n && ( bus.addr[15:14] == ram_window );

	// i/o side only looks at the low byte, two registers per block
	assign io_sel	= !bus.iorq_n && ( bus.addr[7:1] == io_base[7:1] );

	// --------------------
	// read data register
	// --------------------
	always_ff @( posedge clk_pixel ) begin
		if( !ff_reset_n ) begin
			ff_rdata <= 8'hFF;
		end
		else if( ram_ret.en ) begin
			ff_rdata <= ram_ret.data;			// ram wins
		end
		else if( gpio_ret.en ) begin
			ff_rdata <= gpio_ret.data;
		end
		else if( bus.rd_n ) begin
			ff_rdata <= 8'hFF;					// idle bus floats high
		end
		else begin
			ff_rdata <= ff_rdata;				// read in flight, hold
		end
	end

	// unmapped reads get no en pulse and hold what the register had
	assign rdata	= ff_rdata;

endmodule

//--- rtl/labo_pkg.sv
// --------------------
// shared types of the video lab core
// bus cycle, read return and video stream structs plus the fsm enums
// --------------------
`include "labo_settings.svh"

package labo_pkg;

	// plain vectors with a meaning
	typedef logic [15:0]					cpu_addr_t;		// z80 address bus
	typedef logic [7:0]						cpu_data_t;		// z80 data bus
	typedef logic [`RAM_ADDR_BITS-1:0]		ram_addr_t;		// work ram word address
	typedef logic [7:0]						color_t;		// one colour channel
	typedef logic [10:0]					coord_x_t;		// horizontal counter
	typedef logic [9:0]						coord_y_t;		// vertical line counter

	// --------------------
	// one bus cycle as the master drives it, strobes active low
	typedef struct packed {
		logic		mreq_n;
		logic		iorq_n;
		logic		rd_n;
		logic		wr_n;
		cpu_addr_t	addr;
		cpu_data_t	wdata;
	} bus_req_t;

	// registered read answer of a peripheral
	typedef struct packed {
		cpu_data_t	data;
		logic		en;		// one pulse per read edge
	} rd_return_t;

	// --------------------
	// timing of the current pixel
	typedef struct packed {
		logic		hs;
		logic		vs;
		logic		de;
		coord_x_t	x;
		coord_y_t	y;
	} video_pos_t;

	// pixel stream at the board output
	typedef struct packed {
		logic		hs;
		logic		vs;
		logic		de;
		color_t		r;
		color_t		g;
		color_t		b;
	} video_out_t;

	typedef enum logic [1:0] {ACTIVE, FRONT, SYNC, BACK} h_phase_t;

	typedef enum logic [1:0] {
		SOLID	= 2'd0,
		BARS	= 2'd1,
		CHECKER	= 2'd2,
		BLANK	= 2'd3
	} pattern_mode_t;

endpackage

//--- rtl/labo_settings.svh
// --------------------
// board-wide settings for the video lab core
// video timing is shrunk so a whole frame simulates in a few hundred cycles
// include wherever one of the macros below is used
// --------------------
`ifndef LABO_SETTINGS_SVH
`define LABO_SETTINGS_SVH

// --------------------
// horizontal timing, in pixel clocks
`define H_ACTIVE	32
`define H_FRONT		4
`define H_SYNC		4
`define H_BACK		8
`define H_TOTAL		(`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)	// 48 clocks per line

// --------------------
// vertical timing, in lines
`define V_ACTIVE	8
`define V_FRONT		1
`define V_SYNC		2
`define V_BACK		2
`define V_TOTAL		(`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)	// 13 lines per frame

// sync polarity, both positive
`define HS_ACTIVE	1'b1
`define VS_ACTIVE	1'b1

// --------------------
// bus map
`define IO_GPIO_BASE	8'h10	// gpio at 10h-11h
`define RAM_ADDR_BITS	10		// 1 KB work ram

`endif
